// ==== sqrt_defines.svh ====
`ifndef SQRT_DEFINES_SVH
`define SQRT_DEFINES_SVH

// HUB single word layout
`define SQRT_WORD_W   32
`define SQRT_EXP_W    8
`define SQRT_MANT_W   23
`define SQRT_EXP_BIAS 127

// Residual: sign, two integer bits, 26 fraction bits
// Fraction covers significand, ILSB and the guard bit of the quarter scaling
`define SQRT_RES_W    29

// Estimate bits for digit selection
`define SQRT_EST_W    4

// Fraction digits of the root
`define SQRT_ITER     24
`define SQRT_CNT_W    5

// One integer bit plus the fraction digits
`define SQRT_ROOT_W   25

`endif

// ==== sqrt_pkg.sv ====
`include "sqrt_defines.svh"

package sqrt_pkg;

    // Whole HUB word and its fields
    typedef logic [`SQRT_WORD_W-1:0] word_t;
    typedef logic [`SQRT_EXP_W-1:0]  exp_t;
    typedef logic [`SQRT_MANT_W-1:0] mant_t;

    // One carry-save vector or one partial-root addend
    typedef logic [`SQRT_RES_W-1:0]  residual_t;

    // Root form, bit SQRT_ITER has weight one
    typedef logic [`SQRT_ROOT_W-1:0] root_t;

    // Signed digit: 00 zero, 01 plus one, 11 minus one
    typedef logic [1:0]              digit_t;

    typedef logic [`SQRT_CNT_W-1:0]  iter_t;

    typedef enum logic [1:0] {
        SQRT_IDLE    = 2'b00,
        SQRT_ITERATE = 2'b01,
        SQRT_DONE    = 2'b10
    } ctrl_state_t;

endpackage

// ==== sqrt_step_if.sv ====
// One recurrence step, residual unit <-> root converter
interface sqrt_step_if;

    sqrt_pkg::digit_t    digit;  // Root digit of this step
    sqrt_pkg::residual_t f_pos;  // Addend for a +1 digit
    sqrt_pkg::residual_t f_neg;  // Addend for a -1 digit

    // Residual side picks the digit
    modport residual (
        output digit,
        input  f_pos,
        input  f_neg
    );

    // Root side builds the addends from its forms
    modport root (
        input  digit,
        output f_pos,
        output f_neg
    );

endinterface

// ==== sqrt_ctrl.sv ====
`include "sqrt_defines.svh"

module sqrt_ctrl (
    input  logic               clk,
    input  logic               rst_l,
    input  logic               start,
    input  sqrt_pkg::exp_t     x_exp,
    output logic               load,
    output logic               step,
    output logic               done,
    output sqrt_pkg::iter_t    iter,
    output sqrt_pkg::exp_t     res_exp,
    output logic               finish,
    output logic               computing
);

    sqrt_pkg::ctrl_state_t state;
    logic [`SQRT_EXP_W:0]  exp_sum;  // One extra bit for e + bias

    // floor(e_u/2) + bias == floor((e + bias)/2)
    assign exp_sum = {1'b0, x_exp} + (`SQRT_EXP_W+1)'(`SQRT_EXP_BIAS);

    assign load = (state == sqrt_pkg::SQRT_IDLE) && start;  // Only while idle
    assign step = (state == sqrt_pkg::SQRT_ITERATE);
    assign done = (state == sqrt_pkg::SQRT_DONE);

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state     <= sqrt_pkg::SQRT_IDLE;
            iter      <= '0;
            res_exp   <= '0;
            finish    <= 1'b0;
            computing <= 1'b0;
        end else begin
            finish <= 1'b0;  // Single-cycle pulse
            case (state)
                sqrt_pkg::SQRT_IDLE: begin
                    if (start) begin
                        state     <= sqrt_pkg::SQRT_ITERATE;
                        iter      <= sqrt_pkg::iter_t'(1);
                        res_exp   <= exp_sum[`SQRT_EXP_W:1];
                        computing <= 1'b1;
                    end
                end
                sqrt_pkg::SQRT_ITERATE: begin
                    if (iter == sqrt_pkg::iter_t'(`SQRT_ITER)) begin
                        state <= sqrt_pkg::SQRT_DONE;
                        iter  <= '0;
                    end else begin
                        iter <= iter + 1'b1;
                    end
                end
                sqrt_pkg::SQRT_DONE: begin
                    // Result word is registered on this edge too
                    state     <= sqrt_pkg::SQRT_IDLE;
                    finish    <= 1'b1;
                    computing <= 1'b0;
                end
                default: begin
                    state     <= sqrt_pkg::SQRT_IDLE;
                    iter      <= '0;
                    computing <= 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== sqrt_residual.sv ====
`include "sqrt_defines.svh"

module sqrt_residual (
    input  logic               clk,
    input  logic               rst_l,
    input  logic               load,
    input  logic               step,
    input  sqrt_pkg::word_t    x,
    input  sqrt_pkg::iter_t    iter,
    sqrt_step_if.residual      stp,
    output logic               rem_neg
);

    localparam int res_msb = `SQRT_RES_W - 1;

    sqrt_pkg::residual_t ws, wc;             // Carry-save residual
    sqrt_pkg::residual_t ws2, wc2;           // Doubled vectors
    sqrt_pkg::residual_t sig;                // X with one at bit 26
    sqrt_pkg::residual_t sig_scaled;
    sqrt_pkg::residual_t addend;
    sqrt_pkg::residual_t w_final;
    logic [`SQRT_EST_W-1:0] est;
    logic                   odd_exp;
    sqrt_pkg::digit_t       sel;

    // HUB significand, implicit one and ILSB around the field
    assign sig = {2'b00, 1'b1, x[`SQRT_MANT_W-1:0], 1'b1, 2'b00};

    // e_u odd when biased exponent is even
    assign odd_exp    = ~x[`SQRT_MANT_W];
    assign sig_scaled = odd_exp ? (sig >> 1) : (sig >> 2);  // 2X/4 or X/4

    assign ws2 = ws << 1;
    assign wc2 = wc << 1;

    // Estimate of 2W, sign + two integer bits + one fraction bit
    assign est = ws2[res_msb -: `SQRT_EST_W] + wc2[res_msb -: `SQRT_EST_W];

    always_comb begin
        if (est == '1) begin
            sel = 2'b00;                    // -1/2
        end else if (!est[`SQRT_EST_W-1]) begin
            sel = 2'b01;                    // Non-negative
        end else begin
            sel = 2'b11;                    // -1 and below
        end
    end

    // No digit outside a live step
    assign stp.digit = (step && (iter != '0)) ? sel : 2'b00;

    always_comb begin
        case (stp.digit)
            2'b01:   addend = stp.f_pos;
            2'b11:   addend = stp.f_neg;
            default: addend = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            ws <= '0;
            wc <= '0;
        end else if (load) begin
            // W0 = x - 1, the -1 parked in the carry vector
            ws <= sig_scaled;
            wc <= {3'b111, {(`SQRT_RES_W-3){1'b0}}};
        end else if (step) begin
            // 3:2 row on 2WS, 2WC and the addend
            ws <= ws2 ^ wc2 ^ addend;
            wc <= ((ws2 & wc2) | (ws2 & addend) | (wc2 & addend)) << 1;
        end
    end

    assign w_final = ws + wc;     // Assimilated remainder
    assign rem_neg = w_final[res_msb];

endmodule

// ==== sqrt_root_otf.sv ====
`include "sqrt_defines.svh"

module sqrt_root_otf (
    input  logic               clk,
    input  logic               rst_l,
    input  logic               load,
    input  logic               step,
    input  sqrt_pkg::iter_t    iter,
    sqrt_step_if.root          stp,
    output sqrt_pkg::root_t    q,
    output sqrt_pkg::root_t    qm
);

    // Root weight one at bit 24 lands on residual weight two at bit 27
    localparam int two_q_shift = `SQRT_RES_W - `SQRT_ROOT_W - 1;

    sqrt_pkg::root_t     pos_bit;   // 2^-i in root units
    sqrt_pkg::residual_t two_q, two_qm;
    sqrt_pkg::residual_t hi_mask;   // Positions of 2Q[i-1]
    sqrt_pkg::residual_t tail;      // Bits 2^-(i-1) and 2^-i

    assign pos_bit = sqrt_pkg::root_t'(1) << (`SQRT_ITER - iter);

    assign two_q   = sqrt_pkg::residual_t'(q) << two_q_shift;
    assign two_qm  = sqrt_pkg::residual_t'(qm) << two_q_shift;
    assign hi_mask = {`SQRT_RES_W{1'b1}} << (`SQRT_RES_W - 1 - iter);
    assign tail    = sqrt_pkg::residual_t'(3) << (`SQRT_RES_W - 3 - iter);

    // -(2Q + 2^-i) and 2QM + 3*2^-i, no carry needed
    assign stp.f_pos = (~two_q & hi_mask) | tail;
    assign stp.f_neg = two_qm | tail;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            q  <= '0;
            qm <= '0;
        end else if (load) begin
            q  <= sqrt_pkg::root_t'(1) << `SQRT_ITER;  // First digit is 1
            qm <= '0;
        end else if (step) begin
            case (stp.digit)
                2'b01: begin
                    q  <= q | pos_bit;
                    qm <= q;
                end
                2'b11: begin
                    q  <= qm | pos_bit;
                    qm <= qm;
                end
                default: begin
                    qm <= qm | pos_bit;  // Q unchanged
                end
            endcase
        end
    end

endmodule

// ==== sqrt_result.sv ====
`include "sqrt_defines.svh"

module sqrt_result (
    input  logic               clk,
    input  logic               rst_l,
    input  logic               done,
    input  sqrt_pkg::root_t    q,
    input  sqrt_pkg::root_t    qm,
    input  logic               rem_neg,
    input  sqrt_pkg::exp_t     res_exp,
    output sqrt_pkg::word_t    res
);

    sqrt_pkg::root_t q_fin;
    sqrt_pkg::mant_t mant;

    // Negative remainder means Q overshot by one ulp
    assign q_fin = rem_neg ? qm : q;

    // Root of x/4 sits in [1/2,1), leading one at bit 23
    // Integer bit and that leading one both drop out
    assign mant = q_fin[`SQRT_MANT_W-1:0];

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            res <= '0;
        end else if (done) begin
            res <= {1'b0, res_exp, mant};  // Positive result
        end
    end

endmodule

// ==== fphub_sqrt.sv ====
`include "sqrt_defines.svh"

module fphub_sqrt (
    input  logic               clk,
    input  logic               rst_l,
    input  logic               start,
    input  sqrt_pkg::word_t    x,
    output sqrt_pkg::word_t    res,
    output logic               finish,
    output logic               computing
);

    logic            load, step, done;
    logic            rem_neg;
    sqrt_pkg::iter_t iter;
    sqrt_pkg::exp_t  res_exp;
    sqrt_pkg::root_t q, qm;

    sqrt_step_if stp ();

    sqrt_ctrl u_ctrl (
        .clk       (clk),
        .rst_l     (rst_l),
        .start     (start),
        .x_exp     (x[`SQRT_WORD_W-2 -: `SQRT_EXP_W]),
        .load      (load),
        .step      (step),
        .done      (done),
        .iter      (iter),
        .res_exp   (res_exp),
        .finish    (finish),
        .computing (computing)
    );

    sqrt_residual u_residual (
        .clk     (clk),
        .rst_l   (rst_l),
        .load    (load),
        .step    (step),
        .x       (x),
        .iter    (iter),
        .stp     (stp.residual),
        .rem_neg (rem_neg)
    );

    sqrt_root_otf u_root (
        .clk   (clk),
        .rst_l (rst_l),
        .load  (load),
        .step  (step),
        .iter  (iter),
        .stp   (stp.root),
        .q     (q),
        .qm    (qm)
    );

    sqrt_result u_result (
        .clk     (clk),
        .rst_l   (rst_l),
        .done    (done),
        .q       (q),
        .qm      (qm),
        .rem_neg (rem_neg),
        .res_exp (res_exp),
        .res     (res)
    );

endmodule

// ==== sqrt_asserts.sv ====
`include "sqrt_defines.svh"

module sqrt_asserts (
    input logic            clk,
    input logic            rst_l,
    input logic            finish,
    input logic            computing,
    input sqrt_pkg::iter_t iter
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count;   // Read by the testbench at the end

    // Finish is a one-cycle pulse
    finish_pulse: assert property (@(posedge clk) disable iff (!rst_l) finish |=> !finish)
        else begin
            $error("finish stayed high for more than one cycle");
            fail_count++;
        end

    // Computing falls on the finish edge
    busy_exclusive: assert property (@(posedge clk) disable iff (!rst_l) !(finish && computing))
        else begin
            $error("finish and computing high together");
            fail_count++;
        end

    iter_range: assert property (@(posedge clk) disable iff (!rst_l)
                                 iter <= sqrt_pkg::iter_t'(`SQRT_ITER))
        else begin
            $error("iteration counter beyond the last step");
            fail_count++;
        end

endmodule

// ==== tb_fphub_sqrt.sv ====
`include "sqrt_defines.svh"

module tb_fphub_sqrt;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period    = 20;               // 40 ns clock
    localparam int drive_delay    = 2;                // After the rising edge
    localparam int reset_cycles   = 16;
    localparam int finish_timeout = 40;
    localparam int latency        = `SQRT_ITER + 1;   // Edges from sampling to finish
    localparam int random_ops     = 200;

    logic            clk;
    logic            rst_l;
    logic            start;
    sqrt_pkg::word_t x;
    sqrt_pkg::word_t res;
    logic            finish;
    logic            computing;

    logic [31:0] lfsr;
    int          num_checks;
    int          value_errors;
    int          protocol_errors;   // Timeouts and wrong latency
    int          assert_errors;

    fphub_sqrt uut (
        .clk       (clk),
        .rst_l     (rst_l),
        .start     (start),
        .x         (x),
        .res       (res),
        .finish    (finish),
        .computing (computing)
    );

    bind sqrt_ctrl sqrt_asserts u_asserts (
        .clk       (clk),
        .rst_l     (rst_l),
        .finish    (finish),
        .computing (computing),
        .iter      (iter)
    );

    always #half_period clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        int k;
        val = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);        // One step per bit
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // Bit by bit, largest trial first
    function automatic logic [63:0] int_sqrt(input logic [63:0] v);
        logic [63:0] root;
        logic [63:0] trial;
        int          b;
        root = '0;
        for (b = 31; b >= 0; b--) begin
            trial = root | (64'd1 << b);
            if (trial * trial <= v) begin
                root = trial;
            end
        end
        return root;
    endfunction

    // Expected result word for a positive normal HUB operand
    function automatic sqrt_pkg::word_t model_sqrt(input sqrt_pkg::word_t op);
        int          e_u;
        int          r_exp;
        logic [63:0] sig;      // S * 2^24 for even e_u
        logic [63:0] scaled;   // S * 2^46
        logic [63:0] root;
        e_u = int'(op[`SQRT_WORD_W-2 -: `SQRT_EXP_W]) - `SQRT_EXP_BIAS;
        sig = (64'd1 << 24) + (64'(op[`SQRT_MANT_W-1:0]) << 1) + 64'd1;  // ILSB
        if (e_u % 2 != 0) begin
            scaled = sig << 23;            // S = 2X
        end else begin
            scaled = sig << 22;
        end
        r_exp = (e_u >>> 1) + `SQRT_EXP_BIAS;  // Floor for negative e_u too
        root  = int_sqrt(scaled);              // In [2^23, 2^24)
        // Dropping bit 23 subtracts the 2^23
        return {1'b0, sqrt_pkg::exp_t'(r_exp), sqrt_pkg::mant_t'(root[`SQRT_MANT_W-1:0])};
    endfunction

    function automatic sqrt_pkg::word_t make_word(input sqrt_pkg::exp_t e,
                                                  input sqrt_pkg::mant_t m);
        return {1'b0, e, m};
    endfunction

    task automatic check_word(input string name, input sqrt_pkg::word_t got,
                              input sqrt_pkg::word_t exp);
        num_checks++;
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        num_checks++;
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Leaves the caller just after the sampling edge
    task automatic start_op(input sqrt_pkg::word_t operand, output int edges);
        @(posedge clk);
        #drive_delay;
        x     = operand;
        start = 1'b1;
        @(posedge clk);
        #drive_delay;
        start = 1'b0;
        edges = 0;
    endtask

    task automatic wait_finish(inout int edges, input bit hold_check,
                               input sqrt_pkg::word_t held);
        while (finish !== 1'b1 && edges < finish_timeout) begin
            check_bit("computing", computing, 1'b1);
            if (hold_check) begin
                check_word("res", res, held);   // Old result still visible
            end
            @(posedge clk);
            #drive_delay;
            edges++;
        end
        if (finish !== 1'b1) begin
            protocol_errors++;
            $display("Timeout at %0t: finish did not rise within %0d cycles",
                     $time, finish_timeout);
        end else begin
            check_bit("computing", computing, 1'b0);  // Falls with finish
        end
    endtask

    task automatic check_latency(input int edges);
        if (finish === 1'b1 && edges != latency) begin
            protocol_errors++;
            $display("Latency error at %0t: finish came %0d edges after start, not %0d",
                     $time, edges, latency);
        end
    endtask

    task automatic check_op(input sqrt_pkg::word_t operand);
        int edges;
        start_op(operand, edges);
        wait_finish(edges, 1'b0, '0);
        check_word("res", res, model_sqrt(operand));
        check_latency(edges);
    endtask

    task automatic test_reset();
        check_bit("finish", finish, 1'b0);
        check_bit("computing", computing, 1'b0);
        check_word("res", res, '0);
    endtask

    // Both exponent parities
    task automatic test_exact_squares();
        check_op(make_word(8'd127, 23'd0));         // Near 1
        check_op(make_word(8'd129, 23'd0));         // Near 4
        check_op(make_word(8'd128, 23'd0));         // Near 2, odd e_u
        check_op(make_word(8'd126, 23'd0));         // Near 0.5, negative odd
        check_op(make_word(8'd127, '1));            // Just below 2
        check_op(make_word(8'd128, 23'h100000));    // 2.25
    endtask

    task automatic test_latency();
        check_op(make_word(8'd140, 23'h3c0a55));
        @(posedge clk);
        #drive_delay;
        check_bit("finish", finish, 1'b0);          // Single-cycle pulse
        check_bit("computing", computing, 1'b0);
    endtask

    task automatic test_start_busy();
        sqrt_pkg::word_t first_op;
        sqrt_pkg::word_t second_op;
        int              edges;
        first_op  = make_word(8'd130, 23'h2aaaaa);
        second_op = make_word(8'd100, 23'h155555);
        start_op(first_op, edges);
        repeat (5) begin
            @(posedge clk);
            #drive_delay;
            edges++;
        end
        x     = second_op;      // Should be ignored
        start = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #drive_delay;
            edges++;
        end
        start = 1'b0;
        wait_finish(edges, 1'b0, '0);
        check_word("res", res, model_sqrt(first_op));
        check_latency(edges);
        @(posedge clk);
        #drive_delay;
        check_bit("computing", computing, 1'b0);    // No queued start
    endtask

    task automatic test_random();
        logic [31:0]     r;
        sqrt_pkg::exp_t  e;
        sqrt_pkg::mant_t m;
        int              i;
        for (i = 0; i < random_ops; i++) begin
            rand_bits(8, r);
            e = sqrt_pkg::exp_t'(1 + (int'(r[7:0]) % 254));  // 1 to 254
            rand_bits(`SQRT_MANT_W, r);
            m = r[`SQRT_MANT_W-1:0];
            check_op(make_word(e, m));
        end
    endtask

    task automatic test_held();
        sqrt_pkg::word_t first_op;
        sqrt_pkg::word_t second_op;
        sqrt_pkg::word_t held;
        int              edges;
        first_op  = make_word(8'd90, 23'h0f0f0f);
        second_op = make_word(8'd171, 23'h7ffffe);
        check_op(first_op);
        held = model_sqrt(first_op);
        repeat (10) begin
            @(posedge clk);
            #drive_delay;
            check_word("res", res, held);
            check_bit("finish", finish, 1'b0);
        end
        start_op(second_op, edges);
        wait_finish(edges, 1'b1, held);    // res held during the next run
        check_word("res", res, model_sqrt(second_op));
        check_latency(edges);
    endtask

    initial begin
        clk             = 1'b0;
        rst_l           = 1'b0;
        start           = 1'b0;
        x               = '0;
        lfsr            = 32'h52a5_791b;
        num_checks      = 0;
        value_errors    = 0;
        protocol_errors = 0;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_l = 1'b1;

        test_reset();
        test_exact_squares();
        test_latency();
        test_start_busy();
        test_random();
        test_held();

        assert_errors = uut.u_ctrl.u_asserts.fail_count;
        $display("Checks: %0d, value errors: %0d, protocol errors: %0d, assertion errors: %0d",
                 num_checks, value_errors, protocol_errors, assert_errors);
        if (value_errors == 0 && protocol_errors == 0 && assert_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
sqrt_pkg.sv
sqrt_step_if.sv
sqrt_ctrl.sv
sqrt_residual.sv
sqrt_root_otf.sv
sqrt_result.sv
fphub_sqrt.sv
sqrt_asserts.sv
tb_fphub_sqrt.sv

// ==== Makefile ====
TOP := tb_fphub_sqrt

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f build.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
